/* hbus_consts.svh */
// HyperBus bridge constants
`ifndef HBUS_CONSTS_SVH
`define HBUS_CONSTS_SVH

// Address width on both the user and the HyperBus side
`define HBUS_ADDR_W 32

// One HyperBus data beat
`define HBUS_BEAT_W 16

// One user data word, two beats
`define USER_WORD_W 32

// log2 of the entries in each clock-crossing FIFO
`define FIFO_ASIZE 2

// Commands the user may have outstanding after reset
// Matches the command FIFO depth
`define CMD_CREDITS 4

`endif

/* hbus_pkg.sv */
// HyperBus bridge types
`default_nettype none

`include "hbus_consts.svh"

package hbus_pkg;

  // Byte address of one word transfer
  typedef logic [`HBUS_ADDR_W-1:0] hbus_addr_t;

  // Beat on the native memory interface
  typedef logic [`HBUS_BEAT_W-1:0] hbus_beat_t;

  // Word seen by the user port
  typedef logic [`USER_WORD_W-1:0] user_word_t;

  // Entry of the command FIFO, is_read sits in the top bit
  typedef struct packed {
    logic       is_read;
    hbus_addr_t addr;
  } hbus_cmd_t;

  // HyperBus-side sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_WRITE,
    SEQ_READ,
    SEQ_PUSH
  } seq_state_t;

endpackage

`default_nettype wire

/* async_fifo.sv */
// Dual-clock Gray-pointer FIFO
`timescale 1ns/1ps
`default_nettype none

`include "hbus_consts.svh"

module async_fifo #(
  parameter int DSIZE = 32
) (
  input  wire logic             wclk_i,
  input  wire logic             wrst_i,
  input  wire logic             winc_i,
  input  wire logic [DSIZE-1:0] wdata_i,
  output logic                  wfull_o,
  output logic                  wfree_o,

  input  wire logic             rclk_i,
  input  wire logic             rrst_i,
  input  wire logic             rinc_i,
  output logic      [DSIZE-1:0] rdata_o,
  output logic                  rempty_o
);

  localparam int ASIZE = `FIFO_ASIZE;
  localparam int DEPTH = 1 << ASIZE;

  logic [DSIZE-1:0] mem [DEPTH];

  // Pointers carry one extra wrap bit
  logic [ASIZE:0] wbin;
  logic [ASIZE:0] wbin_next;
  logic [ASIZE:0] wgray;
  logic [ASIZE:0] wgray_next;
  logic [ASIZE:0] wq1_rgray;
  logic [ASIZE:0] wq2_rgray;
  logic [ASIZE:0] wq2_rbin;
  logic [ASIZE:0] wfree_bin;

  logic [ASIZE:0] rbin;
  logic [ASIZE:0] rbin_next;
  logic [ASIZE:0] rgray;
  logic [ASIZE:0] rgray_next;
  logic [ASIZE:0] rq1_wgray;
  logic [ASIZE:0] rq2_wgray;

  function automatic logic [ASIZE:0] gray2bin(input logic [ASIZE:0] g);
    logic [ASIZE:0] b;
    b[ASIZE] = g[ASIZE];
    for (int i = ASIZE - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Write domain
  assign wbin_next  = wbin + {{ASIZE{1'b0}}, (winc_i & ~wfull_o)};
  assign wgray_next = (wbin_next >> 1) ^ wbin_next;

  always_ff @(posedge wclk_i) begin
    if (winc_i && !wfull_o) begin
      mem[wbin[ASIZE-1:0]] <= wdata_i;
    end
  end

  always_ff @(posedge wclk_i or posedge wrst_i) begin
    if (wrst_i) begin
      wbin      <= '0;
      wgray     <= '0;
      wq1_rgray <= '0;
      wq2_rgray <= '0;
      wfull_o   <= 1'b0;
    end else begin
      wbin      <= wbin_next;
      wgray     <= wgray_next;
      wq1_rgray <= rgray;
      wq2_rgray <= wq1_rgray;
      // Full when the pointers differ only in the two top Gray bits
      wfull_o   <= (wgray_next == {~wq2_rgray[ASIZE:ASIZE-1], wq2_rgray[ASIZE-2:0]});
    end
  end

  // The synchronized read pointer may jump by more than one slot,
  // so freed slots are paid out one per write clock
  assign wq2_rbin = gray2bin(wq2_rgray);

  always_ff @(posedge wclk_i or posedge wrst_i) begin
    if (wrst_i) begin
      wfree_bin <= '0;
      wfree_o   <= 1'b0;
    end else if (wfree_bin != wq2_rbin) begin
      wfree_bin <= wfree_bin + 1'b1;
      wfree_o   <= 1'b1;
    end else begin
      wfree_o   <= 1'b0;
    end
  end

  // Read domain, head entry is shown without a pop
  assign rdata_o    = mem[rbin[ASIZE-1:0]];
  assign rbin_next  = rbin + {{ASIZE{1'b0}}, (rinc_i & ~rempty_o)};
  assign rgray_next = (rbin_next >> 1) ^ rbin_next;

  always_ff @(posedge rclk_i or posedge rrst_i) begin
    if (rrst_i) begin
      rbin      <= '0;
      rgray     <= '0;
      rq1_wgray <= '0;
      rq2_wgray <= '0;
      rempty_o  <= 1'b1;
    end else begin
      rbin      <= rbin_next;
      rgray     <= rgray_next;
      rq1_wgray <= wgray;
      rq2_wgray <= rq1_wgray;
      rempty_o  <= (rgray_next == rq2_wgray);
    end
  end

endmodule

`default_nettype wire

/* hbus_user_port.sv */
// User-domain command and read port
`timescale 1ns/1ps
`default_nettype none

module hbus_user_port (
  input  wire logic                clk,
  input  wire logic                rst_i,

  // User commands
  input  wire logic                cmd_valid_i,
  input  wire hbus_pkg::hbus_cmd_t  cmd_i,
  input  wire hbus_pkg::user_word_t wdata_i,

  // User responses
  output logic                     credit_o,
  output hbus_pkg::user_word_t     rdata_o,
  output logic                     rd_valid_o,

  // Command and TX FIFO write side
  output logic                     cmd_winc_o,
  output hbus_pkg::hbus_cmd_t      cmd_wdata_o,
  output logic                     tx_winc_o,
  output hbus_pkg::user_word_t     tx_wdata_o,
  input  wire logic                cmd_wfree_i,

  // RX FIFO read side
  input  wire hbus_pkg::user_word_t rx_rdata_i,
  input  wire logic                rx_rempty_i,
  output logic                     rx_rinc_o
);

  // The strobe cycle itself writes the FIFOs on its closing edge
  assign cmd_winc_o  = cmd_valid_i;
  assign cmd_wdata_o = cmd_i;

  // Only writes carry a data word
  assign tx_winc_o  = cmd_valid_i & ~cmd_i.is_read;
  assign tx_wdata_o = wdata_i;

  // RX words never wait, the user has no back-pressure
  assign rx_rinc_o = ~rx_rempty_i;

  always_ff @(posedge clk or posedge rst_i) begin
    if (rst_i) begin
      credit_o   <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      // One credit per command slot freed on the HyperBus side
      credit_o   <= cmd_wfree_i;
      rd_valid_o <= rx_rinc_o;
    end
  end

  // Word is captured on the pop edge and shown with the strobe
  always_ff @(posedge clk) begin
    if (rx_rinc_o) begin
      rdata_o <= rx_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* hbus_sequencer.sv */
// HyperBus-domain command sequencer
`timescale 1ns/1ps
`default_nettype none

module hbus_sequencer (
  input  wire logic                 hbus_clk_i,
  input  wire logic                 rst_i,

  // Command FIFO read side
  input  wire hbus_pkg::hbus_cmd_t  cmd_rdata_i,
  input  wire logic                 cmd_rempty_i,
  output logic                      cmd_rinc_o,

  // TX FIFO read side
  input  wire hbus_pkg::user_word_t tx_rdata_i,
  output logic                      tx_rinc_o,

  // RX FIFO write side
  input  wire logic                 rx_wfull_i,
  output logic                      rx_winc_o,
  output hbus_pkg::user_word_t      rx_wdata_o,

  // Native memory interface
  output hbus_pkg::hbus_addr_t      hbus_adr_o,
  output hbus_pkg::hbus_beat_t      hbus_dat_o,
  input  wire hbus_pkg::hbus_beat_t hbus_dat_i,
  output logic                      hbus_rrq_o,
  output logic                      hbus_wrq_o,
  input  wire logic                 hbus_ready_i,
  input  wire logic                 hbus_valid_i
);

  import hbus_pkg::*;

  localparam int WORD_W = $bits(user_word_t);
  localparam int BEAT_W = $bits(hbus_beat_t);
  localparam int BEATS  = WORD_W / BEAT_W;
  localparam int CNT_W  = (BEATS > 1) ? $clog2(BEATS) : 1;

  seq_state_t       state;
  logic [CNT_W-1:0] beat_cnt;
  logic             last_beat;
  logic             start;
  user_word_t       word_q;

  // A read only starts when its word is sure to fit in the RX FIFO
  assign start = (state == SEQ_IDLE) && !cmd_rempty_i
                 && !(cmd_rdata_i.is_read && rx_wfull_i);

  assign cmd_rinc_o = start;
  assign tx_rinc_o  = start & ~cmd_rdata_i.is_read;

  assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));

  // Top beat of the shift register goes out first
  assign hbus_dat_o = word_q[WORD_W-1 -: BEAT_W];

  assign rx_winc_o  = (state == SEQ_PUSH);
  assign rx_wdata_o = word_q;

  always_ff @(posedge hbus_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state      <= SEQ_IDLE;
      beat_cnt   <= '0;
      hbus_rrq_o <= 1'b0;
      hbus_wrq_o <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            beat_cnt <= '0;
            if (cmd_rdata_i.is_read) begin
              hbus_rrq_o <= 1'b1;
              state      <= SEQ_READ;
            end else begin
              hbus_wrq_o <= 1'b1;
              state      <= SEQ_WRITE;
            end
          end
        end
        SEQ_WRITE: begin
          if (hbus_ready_i) begin
            if (last_beat) begin
              hbus_wrq_o <= 1'b0;
              state      <= SEQ_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        SEQ_READ: begin
          if (hbus_valid_i) begin
            if (last_beat) begin
              hbus_rrq_o <= 1'b0;
              state      <= SEQ_PUSH;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        SEQ_PUSH: begin
          state <= SEQ_IDLE;
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // Address and data word, shared between write and read
  always_ff @(posedge hbus_clk_i) begin
    if (start) begin
      hbus_adr_o <= cmd_rdata_i.addr;
      word_q     <= tx_rdata_i;
    end else if (state == SEQ_WRITE && hbus_ready_i) begin
      word_q <= word_q << BEAT_W;
    end else if (state == SEQ_READ && hbus_valid_i) begin
      word_q <= {word_q[WORD_W-BEAT_W-1:0], hbus_dat_i};
    end
  end

endmodule

`default_nettype wire

/* hbus_fifo_bridge.sv */
// HyperBus clock-domain bridge
`timescale 1ns/1ps
`default_nettype none

module hbus_fifo_bridge (
  input  wire logic                 clk,
  input  wire logic                 hbus_clk_i,
  input  wire logic                 hbus_rst,

  // User interface
  input  wire logic                 cmd_valid_i,
  input  wire hbus_pkg::hbus_cmd_t  cmd_i,
  input  wire hbus_pkg::user_word_t wdata_i,
  output logic                      credit_o,
  output hbus_pkg::user_word_t      rdata_o,
  output logic                      rd_valid_o,

  // HyperBus native interface
  output hbus_pkg::hbus_addr_t      hbus_adr_o,
  output hbus_pkg::hbus_beat_t      hbus_dat_o,
  input  wire hbus_pkg::hbus_beat_t hbus_dat_i,
  output logic                      hbus_rrq_o,
  output logic                      hbus_wrq_o,
  input  wire logic                 hbus_ready_i,
  input  wire logic                 hbus_valid_i
);

  import hbus_pkg::*;

  logic [1:0] user_rst_q;
  logic [1:0] hclk_rst_q;
  logic       user_rst;
  logic       hclk_rst;

  logic       cmd_winc;
  hbus_cmd_t  cmd_wdata;
  logic       cmd_wfree;
  logic       cmd_rinc;
  hbus_cmd_t  cmd_rdata;
  logic       cmd_rempty;

  logic       tx_winc;
  user_word_t tx_wdata;
  logic       tx_rinc;
  user_word_t tx_rdata;

  logic       rx_winc;
  user_word_t rx_wdata;
  logic       rx_wfull;
  logic       rx_rinc;
  user_word_t rx_rdata;
  logic       rx_rempty;

  // Reset asserts at once and leaves each domain on its own clock
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      user_rst_q <= 2'b11;
    end else begin
      user_rst_q <= {user_rst_q[0], 1'b0};
    end
  end

  always_ff @(posedge hbus_clk_i or posedge hbus_rst) begin
    if (hbus_rst) begin
      hclk_rst_q <= 2'b11;
    end else begin
      hclk_rst_q <= {hclk_rst_q[0], 1'b0};
    end
  end

  assign user_rst = user_rst_q[1];
  assign hclk_rst = hclk_rst_q[1];

  hbus_user_port i_hbus_user_port (
    .clk         (clk),
    .rst_i       (user_rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .wdata_i     (wdata_i),
    .credit_o    (credit_o),
    .rdata_o     (rdata_o),
    .rd_valid_o  (rd_valid_o),
    .cmd_winc_o  (cmd_winc),
    .cmd_wdata_o (cmd_wdata),
    .tx_winc_o   (tx_winc),
    .tx_wdata_o  (tx_wdata),
    .cmd_wfree_i (cmd_wfree),
    .rx_rdata_i  (rx_rdata),
    .rx_rempty_i (rx_rempty),
    .rx_rinc_o   (rx_rinc)
  );

  // Credits keep the command FIFO from filling, so its full flag is unused
  async_fifo #(.DSIZE($bits(hbus_cmd_t))) cmd_fifo (
    .wclk_i   (clk),
    .wrst_i   (user_rst),
    .winc_i   (cmd_winc),
    .wdata_i  (cmd_wdata),
    .wfull_o  (),
    .wfree_o  (cmd_wfree),
    .rclk_i   (hbus_clk_i),
    .rrst_i   (hclk_rst),
    .rinc_i   (cmd_rinc),
    .rdata_o  (cmd_rdata),
    .rempty_o (cmd_rempty)
  );

  // Write words travel in step with their commands
  async_fifo #(.DSIZE($bits(user_word_t))) tx_fifo (
    .wclk_i   (clk),
    .wrst_i   (user_rst),
    .winc_i   (tx_winc),
    .wdata_i  (tx_wdata),
    .wfull_o  (),
    .wfree_o  (),
    .rclk_i   (hbus_clk_i),
    .rrst_i   (hclk_rst),
    .rinc_i   (tx_rinc),
    .rdata_o  (tx_rdata),
    .rempty_o ()
  );

  async_fifo #(.DSIZE($bits(user_word_t))) rx_fifo (
    .wclk_i   (hbus_clk_i),
    .wrst_i   (hclk_rst),
    .winc_i   (rx_winc),
    .wdata_i  (rx_wdata),
    .wfull_o  (rx_wfull),
    .wfree_o  (),
    .rclk_i   (clk),
    .rrst_i   (user_rst),
    .rinc_i   (rx_rinc),
    .rdata_o  (rx_rdata),
    .rempty_o (rx_rempty)
  );

  hbus_sequencer i_hbus_sequencer (
    .hbus_clk_i   (hbus_clk_i),
    .rst_i        (hclk_rst),
    .cmd_rdata_i  (cmd_rdata),
    .cmd_rempty_i (cmd_rempty),
    .cmd_rinc_o   (cmd_rinc),
    .tx_rdata_i   (tx_rdata),
    .tx_rinc_o    (tx_rinc),
    .rx_wfull_i   (rx_wfull),
    .rx_winc_o    (rx_winc),
    .rx_wdata_o   (rx_wdata),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i)
  );

endmodule

`default_nettype wire

/* tb_hbus_mem_model.sv */
// HyperBus native memory model
`timescale 1ns/1ps
`default_nettype none

`include "hbus_consts.svh"

module tb_hbus_mem_model (
  input  wire logic                 hbus_clk_i,
  input  wire logic                 rst_i,
  input  wire hbus_pkg::hbus_addr_t hbus_adr_i,
  input  wire hbus_pkg::hbus_beat_t hbus_wdat_i,
  output hbus_pkg::hbus_beat_t      hbus_rdat_o,
  input  wire logic                 hbus_rrq_i,
  input  wire logic                 hbus_wrq_i,
  output logic                      hbus_ready_o,
  output logic                      hbus_valid_o
);

  import hbus_pkg::*;

  // Beats keyed by word address and beat index, index 0 holds the first beat
  hbus_beat_t mem [logic [`HBUS_ADDR_W:0]];

  logic [31:0] lcg_state;
  logic        wr_idx;
  logic        rd_idx;
  logic        rd_idx_next;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Unwritten beats read as zero
  function automatic hbus_beat_t stored_beat(input hbus_addr_t addr, input logic idx);
    if (mem.exists({addr, idx})) begin
      return mem[{addr, idx}];
    end
    return '0;
  endfunction

  assign rd_idx_next = rd_idx ^ (hbus_rrq_i & hbus_valid_o);

  always @(posedge hbus_clk_i or posedge rst_i) begin
    if (rst_i) begin
      lcg_state    <= 32'd74507;
      wr_idx       <= 1'b0;
      rd_idx       <= 1'b0;
      hbus_ready_o <= 1'b0;
      hbus_valid_o <= 1'b0;
      hbus_rdat_o  <= '0;
    end else begin
      lcg_state <= lcg_step(lcg_state);
      if (hbus_wrq_i && hbus_ready_o) begin
        mem[{hbus_adr_i, wr_idx}] = hbus_wdat_i;
        wr_idx <= ~wr_idx;
      end
      rd_idx <= rd_idx_next;
      // Ready and valid only answer a request seen on the previous edge
      hbus_ready_o <= hbus_wrq_i & (lcg_state[17:16] != 2'b00);
      hbus_valid_o <= hbus_rrq_i & (lcg_state[19:18] != 2'b00);
      if (hbus_rrq_i) begin
        hbus_rdat_o <= stored_beat(hbus_adr_i, rd_idx_next);
      end
    end
  end

endmodule

`default_nettype wire

/* tb_hbus_fifo_bridge.sv */
// HyperBus bridge testbench
`timescale 1ns/1ps
`default_nettype none

`include "hbus_consts.svh"

module tb_hbus_fifo_bridge;

  import hbus_pkg::*;

  localparam int N_RAND = 40;
  localparam int N_ZERO = 3;
  // Every command issued by the tests below
  localparam int N_CMDS = 2 + N_RAND + 2 * `CMD_CREDITS + N_ZERO;
  localparam int TIMEOUT_CYCLES = 200 * N_CMDS;

  logic        clk;
  logic        hbus_clk_i;
  logic        hbus_rst;
  logic        cmd_valid_i;
  hbus_cmd_t   cmd_i;
  user_word_t  wdata_i;
  logic        credit_o;
  user_word_t  rdata_o;
  logic        rd_valid_o;
  hbus_addr_t  hbus_adr_o;
  hbus_beat_t  hbus_dat_o;
  hbus_beat_t  hbus_dat_i;
  logic        hbus_rrq_o;
  logic        hbus_wrq_o;
  logic        hbus_ready_i;
  logic        hbus_valid_i;

  user_word_t  ref_mem [hbus_addr_t];
  user_word_t  expect_q [$];
  int          issued;
  int          returned = 0;
  int          cycles = 0;
  logic [31:0] rand_state;

  always #10 clk = ~clk;
  // Unrelated period keeps the two domains drifting against each other
  always #7 hbus_clk_i = ~hbus_clk_i;

  hbus_fifo_bridge i_hbus_fifo_bridge (
    .clk          (clk),
    .hbus_clk_i   (hbus_clk_i),
    .hbus_rst     (hbus_rst),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .wdata_i      (wdata_i),
    .credit_o     (credit_o),
    .rdata_o      (rdata_o),
    .rd_valid_o   (rd_valid_o),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i)
  );

  tb_hbus_mem_model i_hbus_mem_model (
    .hbus_clk_i   (hbus_clk_i),
    .rst_i        (hbus_rst),
    .hbus_adr_i   (hbus_adr_o),
    .hbus_wdat_i  (hbus_dat_o),
    .hbus_rdat_o  (hbus_dat_i),
    .hbus_rrq_i   (hbus_rrq_o),
    .hbus_wrq_i   (hbus_wrq_o),
    .hbus_ready_o (hbus_ready_i),
    .hbus_valid_o (hbus_valid_i)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Word memory as the user sees it
  // Unwritten words read as zero
  function automatic user_word_t ref_access(input logic is_read, input hbus_addr_t addr,
                                            input user_word_t data);
    if (!is_read) begin
      ref_mem[addr] = data;
      return data;
    end
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  // Waits for a free credit, then strobes one command for one cycle
  task automatic issue_cmd(input logic is_read, input hbus_addr_t addr, input user_word_t data);
    user_word_t expected;
    while (issued - returned >= `CMD_CREDITS) begin
      @(posedge clk);
      #2;
    end
    expected = ref_access(is_read, addr, data);
    if (is_read) begin
      expect_q.push_back(expected);
    end
    cmd_valid_i   = 1'b1;
    cmd_i.is_read = is_read;
    cmd_i.addr    = addr;
    wdata_i       = is_read ? '0 : data;
    issued        = issued + 1;
    @(posedge clk);
    #2;
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (expect_q.size() != 0 || returned != issued) begin
      @(posedge clk);
      #2;
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run("timeout waiting for read data or credits");
    end
  end

  always @(posedge clk) begin
    if (credit_o) begin
      if (returned >= issued) begin
        abort_run("credit returned with no command outstanding");
      end else begin
        returned <= returned + 1;
      end
    end
  end

  // Read words must arrive in command order
  always @(posedge clk) begin
    if (rd_valid_o) begin
      if (expect_q.size() == 0) begin
        abort_run("read data returned with no read outstanding");
      end else begin
        check_value("rdata_o", rdata_o, expect_q.pop_front());
      end
    end
  end

  initial begin
    hbus_addr_t addr;
    user_word_t data;
    logic       is_read;

    clk         = 1'b0;
    hbus_clk_i  = 1'b0;
    hbus_rst    = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    wdata_i     = '0;
    issued      = 0;
    rand_state  = 32'd74507;
    repeat (10) @(posedge clk);
    #2;
    hbus_rst = 1'b0;

    // Idle bridge stays quiet on both sides
    repeat (20) begin
      @(posedge clk);
      #2;
      check_value("hbus_rrq_o", 32'(hbus_rrq_o), 32'h0);
      check_value("hbus_wrq_o", 32'(hbus_wrq_o), 32'h0);
      check_value("rd_valid_o", 32'(rd_valid_o), 32'h0);
      check_value("credit_o", 32'(credit_o), 32'h0);
    end

    // Single write and read back, then the two stored beats
    addr = 32'h0000_1000;
    data = 32'hA5C3_1E7F;
    issue_cmd(1'b0, addr, data);
    issue_cmd(1'b1, addr, '0);
    wait_drained();
    check_value("mem_beat_hi", 32'(i_hbus_mem_model.stored_beat(addr, 1'b0)),
                32'(data[31:16]));
    check_value("mem_beat_lo", 32'(i_hbus_mem_model.stored_beat(addr, 1'b1)),
                32'(data[15:0]));

    // Mixed traffic over four words
    for (int n = 0; n < N_RAND; n++) begin
      rand_state = lcg_step(rand_state);
      is_read    = rand_state[20];
      addr       = 32'h0000_0040 + {28'd0, rand_state[23:22], 2'b00};
      rand_state = lcg_step(rand_state);
      issue_cmd(is_read, addr, rand_state);
    end
    wait_drained();

    // Full credit window spent back to back, twice
    for (int n = 0; n < `CMD_CREDITS; n++) begin
      issue_cmd(1'b0, 32'h0000_2000 + 32'(n * 4), 32'hC0DE_0000 + 32'(n));
    end
    for (int n = 0; n < `CMD_CREDITS; n++) begin
      issue_cmd(1'b1, 32'h0000_2000 + 32'(n * 4), '0);
    end
    wait_drained();

    // Never written words
    for (int n = 0; n < N_ZERO; n++) begin
      issue_cmd(1'b1, 32'h0001_0000 + 32'(n * 4), '0);
    end
    wait_drained();

    if (expect_q.size() != 0 || returned != issued) begin
      abort_run("timeout waiting for read data or credits");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
hbus_pkg.sv
async_fifo.sv
hbus_user_port.sv
hbus_sequencer.sv
hbus_fifo_bridge.sv
tb_hbus_mem_model.sv
tb_hbus_fifo_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hbus_fifo_bridge
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^TEST RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
